// ==== common/fetch_pkg.sv ====
// fetch front end shared types
// words, redirect causes and stage packets
package fetch_pkg;

  // basic machine word
  typedef logic [31:0] word_t;  // address or instruction

  // why the backend moved the fetch path
  typedef enum logic [2:0] {
    RD_BRANCH    = 3'd0,  // branch or jump mispredict
    RD_CSR_FLUSH = 3'd1,  // csr write, resume after it
    RD_IFENCE    = 3'd2,  // fence.i, resume after it
    RD_PRIV      = 3'd3,  // trap entry or xret vector
    RD_INTR      = 3'd4   // interrupt, refetch current pc
  } redirect_cause_t;

  // backend redirect request
  typedef struct packed {
    logic            valid;
    redirect_cause_t cause;
    word_t           pc;     // target, flushing instr pc or trap vector
  } redirect_t;

  // branch resolution from the backend
  typedef struct packed {
    logic  valid;
    word_t pc;      // pc of the resolved branch
    word_t target;  // resolved target
    logic  taken;
  } bp_update_t;

  // one instruction handed to decode
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instr;
    logic  predicted_taken;  // btb steered fetch away from pc+4
  } fetch_packet_t;

  // btb lookup result for fetch1
  typedef struct packed {
    logic  taken;   // hit and counter says taken
    word_t target;
  } prediction_t;

  // sizes used when checking connections
  localparam int WORD_W     = $bits(word_t);
  localparam int REDIRECT_W = $bits(redirect_t);
  localparam int UPDATE_W   = $bits(bp_update_t);
  localparam int PACKET_W   = $bits(fetch_packet_t);
  localparam int PRED_W     = $bits(prediction_t);

  // instruction step, no compressed support
  localparam word_t INSTR_BYTES = 32'd4;

endpackage

// ==== fetch/fetch1_stage.sv ====
`timescale 1ns/1ns
// fetch1 stage
// pc register and next pc select
module fetch1_stage #(
  parameter fetch_pkg::word_t RESET_PC = 32'h8000_0000
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   fetch_en,    // request issued this cycle
  input  logic                   load_en,     // redirect or halt
  input  fetch_pkg::word_t       load_pc,     // new path start
  input  fetch_pkg::prediction_t pred,        // btb result for current_pc
  output fetch_pkg::word_t       current_pc,  // also the imem address
  output logic                   pred_taken   // travels with the request
);
  import fetch_pkg::*;

  word_t pc_q;      // fetch pc
  word_t pc_plus4;  // sequential successor
  word_t pred_npc;  // successor after prediction
  word_t next_pc;

  assign pc_plus4 = pc_q + INSTR_BYTES;
  assign pred_npc = pred.taken ? pred.target : pc_plus4;  // taken hit wins

  // load beats fetch beats hold
  always_comb begin
    next_pc = pc_q;  // stalled pc stays
    if (load_en) begin
      next_pc = load_pc;  // new path from controller
    end else if (fetch_en) begin
      next_pc = pred_npc;  // advance past the issued fetch
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= next_pc;
    end
  end

  assign current_pc = pc_q;
  assign pred_taken = pred.taken;  // latched by fetch2 with the pc

  // a load and a fetch in one cycle would issue
  // a request for a pc that fetch1 is already leaving
  property p_load_excl_fetch;
    @(posedge CLK) disable iff (!nRST)
      !(load_en && fetch_en);
  endproperty

  a_load_excl_fetch: assert property (p_load_excl_fetch)
    else $error("fetch1: load_en and fetch_en high together");

endmodule

// ==== fetch/branch_predictor.sv ====
`timescale 1ns/1ns
// branch target buffer
// direct mapped, 2-bit counters
module branch_predictor #(
  parameter int BTB_ENTRIES = 16  // power of two
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  fetch_pkg::word_t       current_pc,  // lookup address
  input  fetch_pkg::bp_update_t  update,      // training from backend
  output fetch_pkg::prediction_t pred
);
  import fetch_pkg::*;

  localparam int IDX_W = $clog2(BTB_ENTRIES);
  localparam int TAG_W = 30 - IDX_W;  // pc bits above the index

  // one btb line
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    word_t            target;
    logic [1:0]       ctr;  // 0,1 not taken; 2,3 taken
  } btb_entry_t;

  btb_entry_t             entries [BTB_ENTRIES];  // payload array
  logic [BTB_ENTRIES-1:0] entry_valid;

  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  btb_entry_t       rd_entry;
  logic             rd_hit;

  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] wr_tag;
  btb_entry_t       wr_entry;  // current contents at the update slot
  btb_entry_t       new_entry;
  logic             wr_hit;
  logic             wr_en;

  // lookup, combinational on the fetch pc
  assign rd_idx   = current_pc[IDX_W+1:2];
  assign rd_tag   = current_pc[31:IDX_W+2];
  assign rd_entry = entries[rd_idx];
  assign rd_hit   = entry_valid[rd_idx] && (rd_entry.tag == rd_tag);

  assign pred.taken  = rd_hit && rd_entry.ctr[1];  // msb set means taken
  assign pred.target = rd_entry.target;

  // training side
  assign wr_idx   = update.pc[IDX_W+1:2];
  assign wr_tag   = update.pc[31:IDX_W+2];
  assign wr_entry = entries[wr_idx];
  assign wr_hit   = entry_valid[wr_idx] && (wr_entry.tag == wr_tag);
  assign wr_en    = update.valid && (wr_hit || update.taken);  // nt miss ignored

  always_comb begin
    new_entry        = wr_entry;
    new_entry.target = update.target;  // refresh target every write
    if (wr_hit) begin
      if (update.taken && (wr_entry.ctr != 2'b11)) begin
        new_entry.ctr = wr_entry.ctr + 2'd1;  // strengthen taken
      end else if (!update.taken && (wr_entry.ctr != 2'b00)) begin
        new_entry.ctr = wr_entry.ctr - 2'd1;  // lean not taken
      end
    end else begin
      new_entry.tag = wr_tag;  // allocate, replaces whatever was there
      new_entry.ctr = 2'b10;   // weakly taken
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      entries[wr_idx] <= new_entry;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      entry_valid <= '0;
    end else if (wr_en) begin
      entry_valid[wr_idx] <= 1'b1;
    end
  end

endmodule

// ==== fetch/fetch2_stage.sv ====
`timescale 1ns/1ns
// fetch2 stage
// pairs pc with returning instruction
module fetch2_stage (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     fetch_en,    // request issued this cycle
  input  logic                     squash,      // drop presented packet
  input  fetch_pkg::word_t         current_pc,
  input  logic                     pred_taken,
  input  fetch_pkg::word_t         imem_rdata,  // data for last cycle's request
  output fetch_pkg::fetch_packet_t packet,
  output logic                     inflight     // request awaiting its data
);
  import fetch_pkg::*;

  logic  valid_q;  // a request went out last cycle
  word_t pc_q;
  logic  taken_q;

  // in-flight flag
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= 1'b0;
    end else if (squash) begin
      valid_q <= 1'b0;  // old path gone
    end else begin
      valid_q <= fetch_en;  // one cycle memory latency
    end
  end

  // request payload
  always_ff @(posedge CLK) begin
    if (fetch_en) begin
      pc_q    <= current_pc;
      taken_q <= pred_taken;
    end
  end

  assign packet.valid           = valid_q && !squash;
  assign packet.pc              = pc_q;
  assign packet.instr           = imem_rdata;  // memory answers now
  assign packet.predicted_taken = taken_q;

  assign inflight = valid_q;

  // squash must kill the packet in the same cycle
  property p_squash_kills;
    @(posedge CLK) disable iff (!nRST)
      squash |-> !packet.valid;
  endproperty

  a_squash_kills: assert property (p_squash_kills)
    else $error("fetch2: packet valid during squash");

endmodule

// ==== verilog/fetch_control.sv ====
`timescale 1ns/1ns
// fetch controller
// redirects, credits and squash
module fetch_control #(
  parameter fetch_pkg::word_t RESET_PC   = 32'h8000_0000,
  parameter int               FQ_CREDITS = 4  // decode queue depth
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 halt,
  input  fetch_pkg::redirect_t redirect,
  input  fetch_pkg::word_t     current_pc,
  input  logic                 inflight,       // fetch2 holds a request
  input  logic                 packet_sent,    // valid packet to decode
  input  logic                 credit_return,  // decode freed one slot
  output logic                 fetch_en,
  output logic                 load_en,
  output logic                 squash,
  output fetch_pkg::word_t     load_pc
);
  import fetch_pkg::*;

  localparam int            CW   = $clog2(FQ_CREDITS + 1);
  localparam logic [CW-1:0] FULL = CW'(FQ_CREDITS);

  logic [CW-1:0] credits;          // free decode slots
  logic [CW-1:0] inflight_cnt;     // 0 or 1 in credit width
  word_t         redirect_target;
  logic          credit_ok;

  // target per cause
  always_comb begin
    case (redirect.cause)
      RD_BRANCH:    redirect_target = redirect.pc;                // resolved target
      RD_PRIV:      redirect_target = redirect.pc;                // trap vector
      RD_CSR_FLUSH: redirect_target = redirect.pc + INSTR_BYTES;  // after the csr op
      RD_IFENCE:    redirect_target = redirect.pc + INSTR_BYTES;  // after fence.i
      RD_INTR:      redirect_target = current_pc;                 // refetch
      default:      redirect_target = redirect.pc;
    endcase
  end

  assign load_en = halt || redirect.valid;
  assign squash  = load_en;                                  // old path dies
  assign load_pc = halt ? RESET_PC : redirect_target;       // halt has priority

  // keep one slot back for a packet already on its way
  assign inflight_cnt = CW'(inflight);
  assign credit_ok    = credits > inflight_cnt;
  assign fetch_en     = !load_en && credit_ok;

  // credit counter
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      credits <= FULL;
    end else if (halt) begin
      credits <= FULL;  // queue restarts empty
    end else begin
      case ({packet_sent, credit_return})
        2'b10:   credits <= credits - CW'(1);  // packet took a slot
        2'b01:   credits <= credits + CW'(1);  // decode freed a slot
        default: credits <= credits;           // none or both
      endcase
    end
  end

  // counter bound
  property p_credit_bound;
    @(posedge CLK) disable iff (!nRST)
      credits <= FULL;
  endproperty

  a_credit_bound: assert property (p_credit_bound)
    else $error("fetch_control: credits above FQ_CREDITS");

  // decode cannot free a slot it never got
  property p_no_extra_return;
    @(posedge CLK) disable iff (!nRST)
      credit_return |-> (credits != FULL);
  endproperty

  a_no_extra_return: assert property (p_no_extra_return)
    else $error("fetch_control: credit_return with full credits");

endmodule

// ==== verilog/fetch_frontend.sv ====
`timescale 1ns/1ns
// fetch front end top
module fetch_frontend #(
  parameter fetch_pkg::word_t RESET_PC    = 32'h8000_0000,
  parameter int               BTB_ENTRIES = 16,
  parameter int               FQ_CREDITS  = 4
) (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     halt,
  input  fetch_pkg::redirect_t     redirect,       // from backend
  input  fetch_pkg::bp_update_t    bp_update,      // from backend
  input  fetch_pkg::word_t         imem_rdata,
  input  logic                     credit_return,  // from decode
  output logic                     imem_req,
  output fetch_pkg::word_t         imem_addr,
  output fetch_pkg::fetch_packet_t packet          // to decode
);
  import fetch_pkg::*;

  word_t       current_pc;
  word_t       load_pc;
  prediction_t pred;
  logic        pred_taken;
  logic        fetch_en;
  logic        load_en;
  logic        squash;
  logic        inflight;

  assign imem_req  = fetch_en;
  assign imem_addr = current_pc;

  fetch1_stage #(.RESET_PC(RESET_PC)) u_fetch1 (
    .CLK, .nRST, .fetch_en, .load_en, .load_pc, .pred, .current_pc, .pred_taken
  );

  branch_predictor #(.BTB_ENTRIES(BTB_ENTRIES)) u_btb (
    .CLK, .nRST, .current_pc, .update(bp_update), .pred
  );

  fetch2_stage u_fetch2 (
    .CLK, .nRST, .fetch_en, .squash, .current_pc, .pred_taken, .imem_rdata,
    .packet, .inflight
  );

  fetch_control #(
    .RESET_PC  (RESET_PC),
    .FQ_CREDITS(FQ_CREDITS)
  ) u_ctrl (
    .CLK, .nRST, .halt, .redirect, .current_pc, .inflight,
    .packet_sent(packet.valid),  // each sent packet costs a credit
    .credit_return, .fetch_en, .load_en, .squash, .load_pc
  );

endmodule

// ==== tb/fetch_frontend_tb.sv ====
`timescale 1ns/1ns
// fetch front end testbench
module fetch_frontend_tb;
  import fetch_pkg::*;

  localparam word_t RESET_PC    = 32'h8000_0000;
  localparam int    BTB_ENTRIES = 16;
  localparam int    FQ_CREDITS  = 4;
  localparam int    NROWS       = 14;
  localparam int    CYCLE_LIMIT = NROWS * 40 + 200;
  localparam word_t IDLE_WORD   = 32'h0000_0013;  // nop on the bus when idle

  typedef enum logic [2:0] {
    A_RUN, A_TRAIN, A_UNTRAIN, A_REDIRECT, A_HALT, A_WITHHOLD
  } action_t;

  typedef struct packed {
    action_t         act;
    redirect_cause_t cause;
    word_t           pc;      // redirect pc or trained branch
    word_t           target;  // trained target
    logic [7:0]      count;   // packets to see after the action
  } row_t;

  logic          CLK;
  logic          nRST;
  logic          halt;
  redirect_t     redirect;
  bp_update_t    bp_update;
  word_t         imem_rdata;
  logic          credit_return;
  logic          imem_req;
  word_t         imem_addr;
  fetch_packet_t packet;

  row_t        rows [NROWS];
  int          dq [$];       // due cycles of packets held by decode
  logic        withhold;     // decode keeps its credits
  logic [31:0] lfsr;
  int          cycle;
  int          errors;
  int          checks;
  int          rx_count;     // valid packets seen
  int          pt_seen;      // packets marked predicted taken
  logic        nxt_halt;     // one-shot inputs for the next tick
  redirect_t   nxt_redirect;
  bp_update_t  nxt_update;
  logic        mem_pending;  // request went out last cycle
  word_t       mem_addr;
  word_t       model_pc;     // expected fetch pc
  logic        exp_valid;    // packet expected this cycle
  word_t       exp_pc;
  logic        exp_pt;
  logic        bt_valid;     // single trained branch
  word_t       bt_pc;
  word_t       bt_target;
  logic [1:0]  bt_ctr;

  fetch_frontend #(
    .RESET_PC   (RESET_PC),
    .BTB_ENTRIES(BTB_ENTRIES),
    .FQ_CREDITS (FQ_CREDITS)
  ) DUT (
    .CLK, .nRST, .halt, .redirect, .bp_update, .imem_rdata, .credit_return,
    .imem_req, .imem_addr, .packet
  );

  always #2 CLK = ~CLK;  // 4 ns period

  // galois lfsr, taps for x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // decode holds a packet 1..4 cycles
  function automatic int draw_delay();
    int d;
    d = 0;
    repeat (2) begin
      lfsr = lfsr_next(lfsr);  // one step per bit
      d = (d << 1) | lfsr[0];
    end
    return d + 1;
  endfunction

  function automatic logic predicts_taken(input word_t pc);
    return bt_valid && (bt_pc == pc) && bt_ctr[1];  // counter 2 or 3
  endfunction

  function automatic word_t redirect_target(input redirect_t r);
    case (r.cause)
      RD_CSR_FLUSH, RD_IFENCE: return r.pc + 32'd4;  // resume after the op
      RD_INTR:                 return model_pc;      // refetch in place
      default:                 return r.pc;          // branch or trap vector
    endcase
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("ERR t=%0t: %s", $time, msg);
  endtask

  // 2-bit counter rules of the btb
  task automatic train_model(input bp_update_t u);
    logic hit;
    hit = bt_valid && (bt_pc == u.pc);
    if (u.valid && hit) begin
      bt_target = u.target;
      if (u.taken && (bt_ctr != 2'd3)) bt_ctr = bt_ctr + 2'd1;
      else if (!u.taken && (bt_ctr != 2'd0)) bt_ctr = bt_ctr - 2'd1;
    end else if (u.valid && u.taken) begin
      bt_valid  = 1'b1;  // allocate weakly taken
      bt_pc     = u.pc;
      bt_target = u.target;
      bt_ctr    = 2'd2;
    end
  endtask

  // one clock: drive on the falling edge, check 1 ns later
  task automatic tick();
    int   held;     // packets decode held at the last edge
    logic load;
    logic exp_req;
    @(negedge CLK);
    cycle++;
    if (cycle > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $finish;
    end
    held = dq.size();
    load = nxt_halt || nxt_redirect.valid;
    nRST          = 1'b1;  // released on the first tick
    halt          = nxt_halt;
    redirect      = nxt_redirect;
    bp_update     = nxt_update;
    imem_rdata    = mem_pending ? ~mem_addr : IDLE_WORD;  // inverted address
    credit_return = 1'b0;
    if (nxt_halt) begin
      dq.delete();  // decode queue restarts empty
    end else if (!withhold && (held > 0) && (dq[0] <= cycle)) begin
      credit_return = 1'b1;
      void'(dq.pop_front());
    end
    if (nxt_halt) model_pc = RESET_PC;
    else if (nxt_redirect.valid) model_pc = redirect_target(nxt_redirect);
    if (load) exp_valid = 1'b0;  // in-flight packet dies
    #1;
    checks++;
    if (packet.valid !== exp_valid) begin
      report_mismatch($sformatf("packet.valid %b, expected %b", packet.valid, exp_valid));
    end
    if (packet.valid && exp_valid) begin
      checks++;
      if (packet.pc !== exp_pc) begin
        report_mismatch($sformatf("pc %h, expected %h", packet.pc, exp_pc));
      end
      if (packet.instr !== ~exp_pc) begin
        report_mismatch($sformatf("instr %h at pc %h", packet.instr, exp_pc));
      end
      if (packet.predicted_taken !== exp_pt) begin
        report_mismatch($sformatf("predicted_taken %b at pc %h", packet.predicted_taken, exp_pc));
      end
    end
    if (packet.valid) begin
      rx_count++;
      pt_seen += packet.predicted_taken;
      dq.push_back(cycle + draw_delay());
      if (dq.size() > FQ_CREDITS) begin
        report_mismatch($sformatf("decode holds %0d packets", dq.size()));
      end
    end
    exp_req = !load && ((FQ_CREDITS - held) > (exp_valid ? 1 : 0));  // credit rule
    if (imem_req !== exp_req) begin
      report_mismatch($sformatf("imem_req %b, expected %b", imem_req, exp_req));
    end
    if (exp_req && (imem_addr !== model_pc)) begin
      report_mismatch($sformatf("imem_addr %h, expected %h", imem_addr, model_pc));
    end
    exp_valid = exp_req;
    exp_pc    = model_pc;
    exp_pt    = predicts_taken(model_pc);  // lookup before this edge's update
    if (exp_req) model_pc = exp_pt ? bt_target : model_pc + 32'd4;
    train_model(nxt_update);
    mem_pending  = imem_req;
    mem_addr     = imem_addr;
    nxt_halt     = 1'b0;
    nxt_redirect = '0;
    nxt_update   = '0;
  endtask

  task automatic run_row(input row_t r);
    int goal;
    int idle_rx;
    case (r.act)
      A_TRAIN: begin
        nxt_update = '{1'b1, r.pc, r.target, 1'b1};
        tick();
      end
      A_UNTRAIN: begin
        repeat (2) begin
          nxt_update = '{1'b1, r.pc, r.target, 1'b0};
          tick();
        end
      end
      A_REDIRECT: begin
        nxt_redirect = '{1'b1, r.cause, r.pc};
        tick();
      end
      A_HALT: begin
        nxt_halt = 1'b1;
        tick();
      end
      A_WITHHOLD: begin
        withhold = 1'b1;
        while (dq.size() < FQ_CREDITS) tick();  // fill every credit
        idle_rx = rx_count;
        repeat (8) tick();
        checks++;
        if (rx_count != idle_rx) begin
          report_mismatch($sformatf("%0d packets with no credits", rx_count - idle_rx));
        end
        withhold = 1'b0;
      end
      default: ;
    endcase
    goal = rx_count + int'(r.count);
    while (rx_count < goal) tick();
  endtask

  initial begin
    CLK           = 1'b0;
    nRST          = 1'b0;
    halt          = 1'b0;
    redirect      = '0;
    bp_update     = '0;
    imem_rdata    = IDLE_WORD;
    credit_return = 1'b0;
    withhold      = 1'b0;
    lfsr          = 32'h28f7_010a;
    cycle         = 0;
    errors        = 0;
    checks        = 0;
    rx_count      = 0;
    pt_seen       = 0;
    nxt_halt      = 1'b0;
    nxt_redirect  = '0;
    nxt_update    = '0;
    mem_pending   = 1'b0;
    mem_addr      = '0;
    model_pc      = RESET_PC;
    exp_valid     = 1'b0;
    exp_pc        = '0;
    exp_pt        = 1'b0;
    bt_valid      = 1'b0;
    bt_pc         = '0;
    bt_target     = '0;
    bt_ctr        = 2'd0;

    rows[0]  = '{A_RUN,      RD_BRANCH,    32'h0,           32'h0,           8'd12};
    rows[1]  = '{A_REDIRECT, RD_BRANCH,    32'h8000_0200, 32'h0,           8'd6};
    rows[2]  = '{A_REDIRECT, RD_CSR_FLUSH, 32'h8000_0300, 32'h0,           8'd6};
    rows[3]  = '{A_REDIRECT, RD_IFENCE,    32'h8000_0340, 32'h0,           8'd6};
    rows[4]  = '{A_REDIRECT, RD_PRIV,      32'h8000_0100, 32'h0,           8'd6};
    rows[5]  = '{A_REDIRECT, RD_INTR,      32'hdead_0000, 32'h0,           8'd6};
    rows[6]  = '{A_WITHHOLD, RD_BRANCH,    32'h0,           32'h0,           8'd8};
    rows[7]  = '{A_TRAIN,    RD_BRANCH,    32'h8000_0410, 32'h8000_0800, 8'd0};
    rows[8]  = '{A_REDIRECT, RD_BRANCH,    32'h8000_0400, 32'h0,           8'd8};
    rows[9]  = '{A_UNTRAIN,  RD_BRANCH,    32'h8000_0410, 32'h8000_0800, 8'd0};
    rows[10] = '{A_REDIRECT, RD_BRANCH,    32'h8000_0400, 32'h0,           8'd8};
    rows[11] = '{A_HALT,     RD_BRANCH,    32'h0,           32'h0,           8'd4};
    rows[12] = '{A_WITHHOLD, RD_BRANCH,    32'h0,           32'h0,           8'd6};
    rows[13] = '{A_RUN,      RD_BRANCH,    32'h0,           32'h0,           8'd6};

    repeat (15) begin
      @(negedge CLK);
      if (packet.valid) report_mismatch("packet valid during reset");
    end
    for (int i = 0; i < NROWS; i++) begin
      run_row(rows[i]);
    end
    checks++;
    if (pt_seen != 1) begin
      report_mismatch($sformatf("%0d predicted-taken packets, expected 1", pt_seen));
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== fetch_frontend.f ====
common/fetch_pkg.sv
fetch/fetch1_stage.sv
fetch/branch_predictor.sv
fetch/fetch2_stage.sv
verilog/fetch_control.sv
verilog/fetch_frontend.sv
tb/fetch_frontend_tb.sv
